//--- logic/filterPkg.sv
package filterPkg;

    localparam int codeBits = 3;
    localparam int numChannels = 3;

    localparam int fixBits = 24;
    localparam int fixFrac = 20;
    localparam int coefBits = 18;
    localparam int coefShift = 16;

    typedef logic [codeBits-1:0] codeT;
    // Q4.20 sample and state
    typedef logic signed [fixBits-1:0] fixT;
    // Q1.16 coefficient
    typedef logic signed [coefBits-1:0] coefT;
    // Full precision sum of two products
    typedef logic signed [fixBits+coefBits:0] accT;

    // Input gains per direction
    localparam coefT inFwdRe [numChannels] = '{3277, 2621, 1966};
    localparam coefT inFwdIm [numChannels] = '{1311, -1966, 655};
    localparam coefT inBwdRe [numChannels] = '{3277, 2621, 1966};
    localparam coefT inBwdIm [numChannels] = '{-1311, 1966, -655};

    localparam coefT poleFwdRe [numChannels] = '{58982, 52429, 45875};
    localparam coefT poleFwdIm [numChannels] = '{6554, 16384, -26214};
    localparam coefT poleBwdRe [numChannels] = '{55706, 49152, 42598};
    localparam coefT poleBwdIm [numChannels] = '{-7864, -19661, 29491};

    localparam coefT wFwdRe [numChannels] = '{32768, 26214, 19661};
    localparam coefT wFwdIm [numChannels] = '{13107, 6554, -9830};
    localparam coefT wBwdRe [numChannels] = '{32768, 26214, 19661};
    localparam coefT wBwdIm [numChannels] = '{-13107, -6554, 9830};

    // Real part of c*s, truncated back to Q4.20
    function automatic fixT cmulRe(input coefT cRe, input coefT cIm, input fixT sRe,
                                   input fixT sIm);
        accT acc;
        acc = cRe * sRe - cIm * sIm;
        return fixT'(acc >>> coefShift);
    endfunction

    function automatic fixT cmulIm(input coefT cRe, input coefT cIm, input fixT sRe,
                                   input fixT sIm);
        accT acc;
        acc = cRe * sIm + cIm * sRe;
        return fixT'(acc >>> coefShift);
    endfunction

endpackage

//--- logic/batchPkg.sv
package batchPkg;

    localparam int batchDepth = 32;
    localparam int addrBits = $clog2(batchDepth);
    typedef logic [addrBits-1:0] addrT;

    // Write, lookahead, idle, forward/backward
    localparam int numBanks = 4;
    typedef logic [$clog2(numBanks)-1:0] bankT;

    localparam int latencyBatches = 4;
    // Bank read, recursion and output register
    localparam int pipeStages = 3;
    localparam int latencyCycles = latencyBatches * batchDepth + pipeStages;

endpackage

//--- logic/batchSequencer.sv
`timescale 1ns/1ps

module batchSequencer (
    input  logic           clk,
    input  logic           rstN,
    output batchPkg::addrT fwdAddr,
    output batchPkg::addrT revAddr,
    output batchPkg::bankT bank,
    output logic           phase,
    output logic           batchStart,
    output logic           outValid
);
    import batchPkg::*;

    localparam int warmBits = $clog2(latencyCycles);

    bankT                batchCount;
    logic [warmBits-1:0] warmCount;

    // Reversed address runs as its own down counter
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            fwdAddr <= '0;
            revAddr <= addrT'(batchDepth - 1);
            batchCount <= '0;
        end else if (fwdAddr == addrT'(batchDepth - 1)) begin
            fwdAddr <= '0;
            revAddr <= addrT'(batchDepth - 1);
            batchCount <= batchCount + 1'b1;
        end else begin
            fwdAddr <= fwdAddr + 1'b1;
            revAddr <= revAddr - 1'b1;
        end
    end

    assign batchStart = (fwdAddr == '0);
    // Batch number wraps with the bank count
    assign bank = batchCount;
    assign phase = batchCount[0];

    // Stops once the first sample has crossed the whole pipeline
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            warmCount <= '0;
            outValid <= 1'b0;
        end else if (!outValid) begin
            if (warmCount == warmBits'(latencyCycles - 1)) begin
                outValid <= 1'b1;
            end else begin
                warmCount <= warmCount + 1'b1;
            end
        end
    end

    addrMirror: assert property (@(posedge clk) disable iff (!rstN)
        ({1'b0, fwdAddr} + {1'b0, revAddr}) == (addrBits + 1)'(batchDepth - 1));

endmodule

//--- logic/sampleBanks.sv
`timescale 1ns/1ps

module sampleBanks (
    input  logic            clk,
    input  logic            rstN,
    input  filterPkg::codeT code,
    input  batchPkg::addrT  fwdAddr,
    input  batchPkg::addrT  revAddr,
    input  batchPkg::bankT  bank,
    output filterPkg::codeT lookCode,
    output filterPkg::codeT fwdCode,
    output filterPkg::codeT bwdCode
);
    import filterPkg::*;
    import batchPkg::*;

    codeT                mem [numBanks][batchDepth];
    logic [numBanks-1:0] bankFilled;
    bankT                lookBank;
    bankT                oldBank;

    // Lookahead reads the batch just stored, forward and backward the oldest
    assign lookBank = bank - bankT'(1);
    assign oldBank = bank - bankT'(3);

    always_ff @(posedge clk) begin
        mem[bank][fwdAddr] <= code;
    end

    // Banks not yet written since reset read as code zero
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            bankFilled <= '0;
            lookCode <= '0;
            fwdCode <= '0;
            bwdCode <= '0;
        end else begin
            bankFilled[bank] <= 1'b1;
            if (bankFilled[lookBank]) begin
                lookCode <= mem[lookBank][revAddr];
            end else begin
                lookCode <= '0;
            end
            if (bankFilled[oldBank]) begin
                fwdCode <= mem[oldBank][fwdAddr];
                bwdCode <= mem[oldBank][revAddr];
            end else begin
                fwdCode <= '0;
                bwdCode <= '0;
            end
        end
    end

    // Bank moves only at a batch start, so no read bank is written mid batch
    noReadOnWrite: assert property (@(posedge clk) disable iff (!rstN)
        (fwdAddr != '0) |-> (bank == $past(bank)));

endmodule

//--- logic/complexRecursion.sv
`timescale 1ns/1ps

module complexRecursion #(
    parameter filterPkg::coefT gainRe = '0,
    parameter filterPkg::coefT gainIm = '0,
    parameter filterPkg::coefT poleRe = '0,
    parameter filterPkg::coefT poleIm = '0
) (
    input  logic            clk,
    input  logic            rstN,
    input  filterPkg::codeT code,
    input  logic            load,
    input  filterPkg::fixT  seedRe,
    input  filterPkg::fixT  seedIm,
    output filterPkg::fixT  stateRe,
    output filterPkg::fixT  stateIm
);
    import filterPkg::*;

    // Gain moved from Q1.16 up to Q4.20
    localparam fixT gainFixRe = fixT'(gainRe) <<< (fixFrac - coefShift);
    localparam fixT gainFixIm = fixT'(gainIm) <<< (fixFrac - coefShift);

    fixT inRe;
    fixT inIm;
    fixT baseRe;
    fixT baseIm;
    fixT nextRe;
    fixT nextIm;

    // Each code bit adds or removes one gain
    always_comb begin
        inRe = '0;
        inIm = '0;
        for (int j = 0; j < codeBits; j++) begin
            if (code[j]) begin
                inRe = inRe + gainFixRe;
                inIm = inIm + gainFixIm;
            end else begin
                inRe = inRe - gainFixRe;
                inIm = inIm - gainFixIm;
            end
        end
    end

    assign baseRe = load ? seedRe : stateRe;
    assign baseIm = load ? seedIm : stateIm;
    assign nextRe = cmulRe(poleRe, poleIm, baseRe, baseIm) + inRe;
    assign nextIm = cmulIm(poleRe, poleIm, baseRe, baseIm) + inIm;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            stateRe <= '0;
            stateIm <= '0;
        end else begin
            stateRe <= nextRe;
            stateIm <= nextIm;
        end
    end

endmodule

//--- logic/filterChannel.sv
`timescale 1ns/1ps

module filterChannel #(
    parameter int chan = 0
) (
    input  logic            clk,
    input  logic            rstN,
    input  filterPkg::codeT lookCode,
    input  filterPkg::codeT fwdCode,
    input  filterPkg::codeT bwdCode,
    input  batchPkg::addrT  fwdAddr,
    input  batchPkg::addrT  revAddr,
    input  logic            phase,
    input  logic            batchStart,
    output filterPkg::fixT  partial
);
    import filterPkg::*;
    import batchPkg::*;

    logic       startD1;
    addrT       fwdAddrD1;
    addrT       fwdAddrD2;
    addrT       revAddrD1;
    addrT       revAddrD2;
    logic       phaseD1;
    logic       phaseD2;
    logic [1:0] halfFilled;
    logic       readHalf;

    fixT lookRe;
    fixT lookIm;
    fixT fwdRe;
    fixT fwdIm;
    fixT bwdRe;
    fixT bwdIm;
    fixT resFwd;
    fixT resBwd;
    fixT fwdRead;
    fixT bwdRead;

    fixT fwdMem [2][batchDepth];
    fixT bwdMem [2][batchDepth];

    // Align start with bank read data, addresses with recursion state
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            startD1 <= 1'b0;
            fwdAddrD1 <= '0;
            fwdAddrD2 <= '0;
            revAddrD1 <= '0;
            revAddrD2 <= '0;
            phaseD1 <= 1'b0;
            phaseD2 <= 1'b0;
            halfFilled <= '0;
        end else begin
            startD1 <= batchStart;
            fwdAddrD1 <= fwdAddr;
            fwdAddrD2 <= fwdAddrD1;
            revAddrD1 <= revAddr;
            revAddrD2 <= revAddrD1;
            phaseD1 <= phase;
            phaseD2 <= phaseD1;
            halfFilled[phaseD2] <= 1'b1;
        end
    end

    // Lookahead restarts from zero on every batch
    complexRecursion #(
        .gainRe(inBwdRe[chan]),
        .gainIm(inBwdIm[chan]),
        .poleRe(poleBwdRe[chan]),
        .poleIm(poleBwdIm[chan])
    ) i_look (
        .clk(clk),
        .rstN(rstN),
        .code(lookCode),
        .load(startD1),
        .seedRe('0),
        .seedIm('0),
        .stateRe(lookRe),
        .stateIm(lookIm)
    );

    // Forward state runs on across batches
    complexRecursion #(
        .gainRe(inFwdRe[chan]),
        .gainIm(inFwdIm[chan]),
        .poleRe(poleFwdRe[chan]),
        .poleIm(poleFwdIm[chan])
    ) i_fwd (
        .clk(clk),
        .rstN(rstN),
        .code(fwdCode),
        .load(1'b0),
        .seedRe('0),
        .seedIm('0),
        .stateRe(fwdRe),
        .stateIm(fwdIm)
    );

    // On start the lookahead register still holds its finished pass
    complexRecursion #(
        .gainRe(inBwdRe[chan]),
        .gainIm(inBwdIm[chan]),
        .poleRe(poleBwdRe[chan]),
        .poleIm(poleBwdIm[chan])
    ) i_bwd (
        .clk(clk),
        .rstN(rstN),
        .code(bwdCode),
        .load(startD1),
        .seedRe(lookRe),
        .seedIm(lookIm),
        .stateRe(bwdRe),
        .stateIm(bwdIm)
    );

    assign resFwd = cmulRe(wFwdRe[chan], wFwdIm[chan], fwdRe, fwdIm);
    assign resBwd = cmulRe(wBwdRe[chan], wBwdIm[chan], bwdRe, bwdIm);

    always_ff @(posedge clk) begin
        fwdMem[phaseD2][fwdAddrD2] <= resFwd;
        bwdMem[phaseD2][revAddrD2] <= resBwd;
    end

    // Other half holds the previous batch, read in sample order
    assign readHalf = ~phaseD2;
    assign fwdRead = fwdMem[readHalf][fwdAddrD2];
    assign bwdRead = bwdMem[readHalf][fwdAddrD2];
    assign partial = halfFilled[readHalf] ? fwdRead + bwdRead : '0;

endmodule

//--- logic/batchFilterTop.sv
`timescale 1ns/1ps

module batchFilterTop (
    input  logic            clk,
    input  logic            rstN,
    input  filterPkg::codeT code,
    output filterPkg::fixT  outSample,
    output logic            outValid
);
    import filterPkg::*;
    import batchPkg::*;

    addrT fwdAddr;
    addrT revAddr;
    bankT bank;
    logic phase;
    logic batchStart;
    codeT lookCode;
    codeT fwdCode;
    codeT bwdCode;
    fixT  partial [numChannels];
    fixT  channelSum;

    batchSequencer i_sequencer (
        .clk(clk),
        .rstN(rstN),
        .fwdAddr(fwdAddr),
        .revAddr(revAddr),
        .bank(bank),
        .phase(phase),
        .batchStart(batchStart),
        .outValid(outValid)
    );

    sampleBanks i_banks (
        .clk(clk),
        .rstN(rstN),
        .code(code),
        .fwdAddr(fwdAddr),
        .revAddr(revAddr),
        .bank(bank),
        .lookCode(lookCode),
        .fwdCode(fwdCode),
        .bwdCode(bwdCode)
    );

    for (genvar c = 0; c < numChannels; c++) begin : g_chan
        filterChannel #(
            .chan(c)
        ) i_channel (
            .clk(clk),
            .rstN(rstN),
            .lookCode(lookCode),
            .fwdCode(fwdCode),
            .bwdCode(bwdCode),
            .fwdAddr(fwdAddr),
            .revAddr(revAddr),
            .phase(phase),
            .batchStart(batchStart),
            .partial(partial[c])
        );
    end

    // Wrapping sum in channel order
    always_comb begin
        channelSum = '0;
        for (int c = 0; c < numChannels; c++) begin
            channelSum = channelSum + partial[c];
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            outSample <= '0;
        end else begin
            outSample <= channelSum;
        end
    end

    // Result memories are fully written before the first valid sample
    sampleKnown: assert property (@(posedge clk) disable iff (!rstN)
        outValid |-> !$isunknown(outSample));

endmodule

//--- bench/batchFilterTb.sv
`timescale 1ns/1ps

module batchFilterTb;
    import filterPkg::*;
    import batchPkg::*;

    localparam int resetCycles = 8;
    localparam int latency = latencyBatches * batchDepth + 3;
    // Forward pass trails the input by three banks and the read stage
    localparam int fwdLead = 3 * batchDepth + 1;
    localparam int numSegments = 2;
    localparam int marginCycles = 100;

    localparam int patZeros = 0;
    localparam int patOnes = 1;
    localparam int patAlternate = 2;
    localparam int patWalk = 3;
    localparam int patRandom = 4;

    // Pattern, batches
    localparam int numRows = 5;
    localparam int stimTable [numRows][2] = '{
        '{patZeros, 2},
        '{patOnes, 2},
        '{patAlternate, 2},
        '{patWalk, 3},
        '{patRandom, 6}
    };
    // Reset is pulsed again in front of this row
    localparam int restartRow = 4;

    logic clk;
    logic rstN;
    codeT code;
    fixT  outSample;
    logic outValid;

    codeT        seq[$];
    fixT         expected[$];
    int          valueErrors;
    int          validErrors;
    int          cycleCount;
    int          cycleLimit;
    int unsigned lcgState;

    batchFilterTop i_dut (
        .clk(clk),
        .rstN(rstN),
        .code(code),
        .outSample(outSample),
        .outValid(outValid)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > cycleLimit) begin
            $display("Timeout, the run did not finish within %0d cycles", cycleLimit);
            $display("Errors: outSample %0d, outValid %0d", valueErrors, validErrors);
            $display("=== FAIL ===");
            $finish;
        end
    end

    function automatic codeT nextRandom();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return codeT'(lcgState >> 16);
    endfunction

    // Codes outside the stimulus read as zero
    function automatic codeT codeAt(input int n);
        if (n < 0 || n >= seq.size()) begin
            return '0;
        end
        return seq[n];
    endfunction

    function automatic fixT weightRe(input coefT wRe, input coefT wIm, input fixT sRe,
                                     input fixT sIm);
        longint acc;
        acc = longint'(wRe) * sRe - longint'(wIm) * sIm;
        return fixT'(acc >>> coefShift);
    endfunction

    // state' = trunc(pole * state) + sum of signed gains
    task automatic stepPole(input coefT pRe, input coefT pIm, input coefT gRe,
                            input coefT gIm, input codeT c, inout fixT sRe, inout fixT sIm);
        longint lut;
        longint prodRe;
        longint prodIm;
        fixT    nextRe;
        lut = 2 * $countones(c) - codeBits;
        prodRe = longint'(pRe) * sRe - longint'(pIm) * sIm;
        prodIm = longint'(pRe) * sIm + longint'(pIm) * sRe;
        nextRe = fixT'(prodRe >>> coefShift)
            + fixT'(lut * (longint'(gRe) <<< (fixFrac - coefShift)));
        sIm = fixT'(prodIm >>> coefShift)
            + fixT'(lut * (longint'(gIm) <<< (fixFrac - coefShift)));
        sRe = nextRe;
    endtask

    task automatic appendPattern(input int pattern, input int batches);
        codeT c;
        for (int i = 0; i < batches * batchDepth; i++) begin
            case (pattern)
                patOnes: c = '1;
                patAlternate: c = (i % 2 == 1) ? codeT'('1) : codeT'('0);
                patWalk: c = codeT'(1 << (i % codeBits));
                patRandom: c = nextRandom();
                default: c = '0;
            endcase
            seq.push_back(c);
        end
    endtask

    task automatic buildExpected();
        fixT fRe;
        fixT fIm;
        fixT lRe;
        fixT lIm;
        fixT bRe;
        fixT bIm;
        int  base;
        expected.delete();
        repeat (seq.size()) expected.push_back('0);
        for (int ch = 0; ch < numChannels; ch++) begin
            fRe = '0;
            fIm = '0;
            for (int n = -fwdLead; n < seq.size(); n++) begin
                stepPole(poleFwdRe[ch], poleFwdIm[ch], inFwdRe[ch], inFwdIm[ch], codeAt(n),
                         fRe, fIm);
                if (n >= 0) begin
                    expected[n] = expected[n] + weightRe(wFwdRe[ch], wFwdIm[ch], fRe, fIm);
                end
            end
            for (int j = 0; j < seq.size() / batchDepth; j++) begin
                base = j * batchDepth;
                // Lookahead over the next batch, from zero
                lRe = '0;
                lIm = '0;
                for (int b = batchDepth - 1; b >= 0; b--) begin
                    stepPole(poleBwdRe[ch], poleBwdIm[ch], inBwdRe[ch], inBwdIm[ch],
                             codeAt(base + batchDepth + b), lRe, lIm);
                end
                bRe = lRe;
                bIm = lIm;
                for (int b = batchDepth - 1; b >= 0; b--) begin
                    stepPole(poleBwdRe[ch], poleBwdIm[ch], inBwdRe[ch], inBwdIm[ch],
                             codeAt(base + b), bRe, bIm);
                    expected[base + b] = expected[base + b]
                        + weightRe(wBwdRe[ch], wBwdIm[ch], bRe, bIm);
                end
            end
        end
    endtask

    task automatic runSegment();
        int total;
        buildExpected();
        // Also lands on a DUT that is still streaming
        for (int i = 0; i < resetCycles; i++) begin
            @(posedge clk);
            rstN <= 1'b0;
            code <= '0;
            @(negedge clk);
            assert (outValid === 1'b0) else begin
                validErrors++;
                $display("** Error outValid in reset expected %h actual %h", 1'b0, outValid);
            end
        end
        total = seq.size() + latency;
        for (int c = 0; c < total; c++) begin
            @(posedge clk);
            rstN <= 1'b1;
            code <= codeAt(c);
            @(negedge clk);
            assert (outValid === (c >= latency)) else begin
                validErrors++;
                $display("** Error outValid cycle %0d expected %h actual %h",
                         c, c >= latency, outValid);
            end
            if (c >= latency) begin
                assert (outSample === expected[c - latency]) else begin
                    valueErrors++;
                    $display("** Error outSample sample %0d expected %h actual %h",
                             c - latency, expected[c - latency], outSample);
                end
            end
        end
    endtask

    initial begin
        int totalBatches;
        rstN = 1'b0;
        code = '0;
        valueErrors = 0;
        validErrors = 0;
        cycleCount = 0;
        lcgState = 56937;
        totalBatches = 0;
        for (int r = 0; r < numRows; r++) begin
            totalBatches += stimTable[r][1];
        end
        cycleLimit = totalBatches * batchDepth + numSegments * (resetCycles + latency)
            + marginCycles;

        seq.delete();
        for (int r = 0; r < numRows; r++) begin
            if (r == restartRow) begin
                runSegment();
                seq.delete();
            end
            appendPattern(stimTable[r][0], stimTable[r][1]);
        end
        runSegment();

        $display("Errors: outSample %0d, outValid %0d", valueErrors, validErrors);
        if (valueErrors + validErrors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- batchFilterTop.f
logic/filterPkg.sv
logic/batchPkg.sv
logic/batchSequencer.sv
logic/sampleBanks.sv
logic/complexRecursion.sv
logic/filterChannel.sv
logic/batchFilterTop.sv
bench/batchFilterTb.sv

//--- Bender.yml
package:
  name: batch_filter

sources:
  - files:
      - logic/filterPkg.sv
      - logic/batchPkg.sv
      - logic/batchSequencer.sv
      - logic/sampleBanks.sv
      - logic/complexRecursion.sv
      - logic/filterChannel.sv
      - logic/batchFilterTop.sv
  - target: test
    files:
      - bench/batchFilterTb.sv
